// File: bootPkg.sv
package bootPkg;

    // Width of one boot image word
    localparam int bootDatW = 16;

    // Index width inside a single memory.
    // Instruction memory uses the full range, data memory the lower half
    localparam int bootIdxW = 10;

    // Wishbone word address
    // Top bit selects the data memory, the low bits carry the index
    localparam int bootAdrW = bootIdxW + 1;

    // Destination memory of an entry, matches the address top bit
    typedef enum logic {
        targetInst = 1'b0,
        targetData = 1'b1
    } bootTarget_t;

endpackage

// File: bootImageRom.sv
`timescale 1ns/1ps

module bootImageRom #(
    parameter int instWords = 1024,
    parameter int dataWords = 512
) (
    input  bootPkg::bootTarget_t              target,
    input  logic [bootPkg::bootIdxW-1:0]      idx,
    output logic [bootPkg::bootDatW-1:0]      value
);
    import bootPkg::*;

    // Image generation constants
    localparam logic [bootDatW-1:0] instMul  = 16'h1F3D;
    localparam logic [bootDatW-1:0] instBase = 16'h0101;
    localparam logic [bootDatW-1:0] dataMul  = 16'h2B47;
    localparam logic [bootDatW-1:0] dataMask = 16'hC35A;

    logic [bootDatW-1:0] idxWide;
    logic [bootDatW-1:0] instWord;
    logic [bootDatW-1:0] dataWord;

    assign idxWide = bootDatW'(idx);

    // Products wrap at the word width
    assign instWord = idxWide * instMul + instBase;
    assign dataWord = (idxWide * dataMul) ^ dataMask;

    // Indices past the end of a memory read as zero
    always_comb begin
        value = '0;
        case (target)
            targetInst: begin
                if (idx < instWords) begin
                    value = instWord;
                end
            end
            targetData: begin
                if (idx < dataWords) begin
                    value = dataWord;
                end
            end
            default: begin
                value = '0;
            end
        endcase
    end

endmodule

// File: flashSequencer.sv
`timescale 1ns/1ps

module flashSequencer #(
    parameter int instWords = 1024,
    parameter int dataWords = 512,
    parameter int mmioStart = 192,
    parameter int mmioEnd   = 255
) (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              flashInit,
    input  logic                              full,
    output logic                              pushValid,
    output bootPkg::bootTarget_t              pushTarget,
    output logic [bootPkg::bootIdxW-1:0]      pushIdx,
    output logic [bootPkg::bootDatW-1:0]      pushData,
    output logic                              seqDone
);
    import bootPkg::*;

    localparam logic [1:0] stIdle    = 2'd0;
    localparam logic [1:0] stRunning = 2'd1;
    localparam logic [1:0] stDone    = 2'd2;

    // First and last data index actually loaded, the window may touch either end
    localparam int firstData = (mmioStart == 0) ? mmioEnd + 1 : 0;
    localparam int lastData  = (mmioEnd >= dataWords - 1) ? mmioStart - 1 : dataWords - 1;

    logic [1:0]          state;
    logic [bootAdrW-1:0] flashAdr;
    logic [bootAdrW-1:0] nextAdr;
    logic                accept;
    logic                lastInst;
    logic                atSkip;
    logic                lastPush;

    // Top address bit picks the memory, as on the bus
    assign pushTarget = bootTarget_t'(flashAdr[bootAdrW-1]);
    assign pushIdx    = flashAdr[bootIdxW-1:0];
    assign pushValid  = (state == stRunning);
    assign seqDone    = (state == stDone);
    assign accept     = pushValid && !full;

    assign lastInst = (pushTarget == targetInst) && (pushIdx == bootIdxW'(instWords - 1));
    assign atSkip   = (pushTarget == targetData) && (mmioStart > 0)
                      && (pushIdx == bootIdxW'(mmioStart - 1));
    assign lastPush = (pushTarget == targetData) && (pushIdx == bootIdxW'(lastData));

    // Next address, the reserved window is stepped over in one move
    always_comb begin
        if (lastInst) begin
            nextAdr = {targetData, bootIdxW'(firstData)};
        end else if (atSkip) begin
            nextAdr = {targetData, bootIdxW'(mmioEnd + 1)};
        end else begin
            nextAdr = flashAdr + 1'b1;
        end
    end

    // One-shot walk, idle is only left once per reset
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= stIdle;
            flashAdr <= '0;
        end else begin
            case (state)
                stIdle: begin
                    if (flashInit) begin
                        state    <= stRunning;
                        flashAdr <= '0;
                    end
                end
                stRunning: begin
                    if (accept) begin
                        flashAdr <= nextAdr;
                        if (lastPush) begin
                            state <= stDone;
                        end
                    end
                end
                stDone: begin
                    state <= stDone;
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // Image word for the entry on offer
    bootImageRom #(
        .instWords(instWords),
        .dataWords(dataWords)
    ) imageRom (
        .target(pushTarget),
        .idx   (pushIdx),
        .value (pushData)
    );

endmodule

// File: bootFifo.sv
`timescale 1ns/1ps

module bootFifo #(
    parameter int fifoDepth = 4
) (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              pushValid,
    input  bootPkg::bootTarget_t              pushTarget,
    input  logic [bootPkg::bootIdxW-1:0]      pushIdx,
    input  logic [bootPkg::bootDatW-1:0]      pushData,
    input  logic                              pop,
    output logic                              full,
    output logic                              popValid,
    output bootPkg::bootTarget_t              popTarget,
    output logic [bootPkg::bootIdxW-1:0]      popIdx,
    output logic [bootPkg::bootDatW-1:0]      popData
);
    import bootPkg::*;

    localparam int ptrW = $clog2(fifoDepth);

    // Entry storage, one array per field
    bootTarget_t         targetMem [fifoDepth];
    logic [bootIdxW-1:0] idxMem    [fifoDepth];
    logic [bootDatW-1:0] dataMem   [fifoDepth];

    // Extra top bit tells a full buffer from an empty one
    logic [ptrW:0] wrPtr;
    logic [ptrW:0] rdPtr;
    logic          doPush;
    logic          doPop;

    assign doPush = pushValid && !full;
    assign doPop  = pop && popValid;

    assign full     = (wrPtr[ptrW] != rdPtr[ptrW])
                      && (wrPtr[ptrW-1:0] == rdPtr[ptrW-1:0]);
    assign popValid = (wrPtr != rdPtr);

    // Head entry
    assign popTarget = targetMem[rdPtr[ptrW-1:0]];
    assign popIdx    = idxMem[rdPtr[ptrW-1:0]];
    assign popData   = dataMem[rdPtr[ptrW-1:0]];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            targetMem[wrPtr[ptrW-1:0]] <= pushTarget;
            idxMem[wrPtr[ptrW-1:0]]    <= pushIdx;
            dataMem[wrPtr[ptrW-1:0]]   <= pushData;
        end
    end

endmodule

// File: wbBootMaster.sv
`timescale 1ns/1ps

module wbBootMaster (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              popValid,
    input  bootPkg::bootTarget_t              popTarget,
    input  logic [bootPkg::bootIdxW-1:0]      popIdx,
    input  logic [bootPkg::bootDatW-1:0]      popData,
    input  logic                              wbAck,
    output logic                              pop,
    output logic                              wbCyc,
    output logic                              wbStb,
    output logic                              wbWe,
    output logic [bootPkg::bootAdrW-1:0]      wbAdr,
    output logic [bootPkg::bootDatW-1:0]      wbDatO,
    output logic                              writesPending
);
    import bootPkg::*;

    // Low is idle, high is a bus cycle in flight
    logic                busy;
    logic [bootAdrW-1:0] adrReg;
    logic [bootDatW-1:0] datReg;

    // Take an entry only between bus cycles
    assign pop = !busy && popValid;

    // Single write, all qualifiers follow the FSM
    assign wbCyc  = busy;
    assign wbStb  = busy;
    assign wbWe   = busy;
    assign wbAdr  = adrReg;
    assign wbDatO = datReg;

    // A cycle ending on this edge no longer counts
    assign writesPending = (busy && !wbAck) || pop;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy <= 1'b0;
        end else begin
            if (!busy) begin
                if (pop) begin
                    busy <= 1'b1;
                end
            end else if (wbAck) begin
                // Back to idle for at least one cycle
                busy <= 1'b0;
            end
        end
    end

    // Address and data held steady for the whole cycle
    always_ff @(posedge clk) begin
        if (pop) begin
            adrReg <= {popTarget, popIdx};
            datReg <= popData;
        end
    end

endmodule

// File: bootLoaderTop.sv
`timescale 1ns/1ps

module bootLoaderTop #(
    parameter int instWords = 1024,
    parameter int dataWords = 512,
    parameter int mmioStart = 192,
    parameter int mmioEnd   = 255,
    parameter int fifoDepth = 4
) (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              flashInit,
    input  logic                              wbAck,
    output logic                              wbCyc,
    output logic                              wbStb,
    output logic                              wbWe,
    output logic [bootPkg::bootAdrW-1:0]      wbAdr,
    output logic [bootPkg::bootDatW-1:0]      wbDatO,
    output logic                              systemEnable
);
    import bootPkg::*;

    // Sequencer to FIFO
    logic                pushValid;
    bootTarget_t         pushTarget;
    logic [bootIdxW-1:0] pushIdx;
    logic [bootDatW-1:0] pushData;
    logic                fifoFull;

    // FIFO to master
    logic                popValid;
    bootTarget_t         popTarget;
    logic [bootIdxW-1:0] popIdx;
    logic [bootDatW-1:0] popData;
    logic                pop;

    logic                seqDone;
    logic                writesPending;

    flashSequencer #(
        .instWords(instWords),
        .dataWords(dataWords),
        .mmioStart(mmioStart),
        .mmioEnd  (mmioEnd)
    ) sequencer (
        .clk       (clk),
        .rstN      (rstN),
        .flashInit (flashInit),
        .full      (fifoFull),
        .pushValid (pushValid),
        .pushTarget(pushTarget),
        .pushIdx   (pushIdx),
        .pushData  (pushData),
        .seqDone   (seqDone)
    );

    bootFifo #(
        .fifoDepth(fifoDepth)
    ) fifo (
        .clk       (clk),
        .rstN      (rstN),
        .pushValid (pushValid),
        .pushTarget(pushTarget),
        .pushIdx   (pushIdx),
        .pushData  (pushData),
        .pop       (pop),
        .full      (fifoFull),
        .popValid  (popValid),
        .popTarget (popTarget),
        .popIdx    (popIdx),
        .popData   (popData)
    );

    wbBootMaster master (
        .clk          (clk),
        .rstN         (rstN),
        .popValid     (popValid),
        .popTarget    (popTarget),
        .popIdx       (popIdx),
        .popData      (popData),
        .wbAck        (wbAck),
        .pop          (pop),
        .wbCyc        (wbCyc),
        .wbStb        (wbStb),
        .wbWe         (wbWe),
        .wbAdr        (wbAdr),
        .wbDatO       (wbDatO),
        .writesPending(writesPending)
    );

    // Sticky enable once everything has landed in memory
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            systemEnable <= 1'b0;
        end else if (seqDone && !popValid && !writesPending) begin
            systemEnable <= 1'b1;
        end
    end

endmodule

// File: tbBootLoader.sv
`timescale 1ns/1ps

module tbBootLoader;
    import bootPkg::*;

    localparam int instWordsTb = 64;
    localparam int dataWordsTb = 32;
    localparam int mmioStartTb = 8;
    localparam int mmioEndTb   = 15;
    localparam int fifoDepthTb = 4;

    localparam int expectedWrites = instWordsTb + dataWordsTb - (mmioEndTb - mmioStartTb + 1);
    // Up to five strobe cycles, one idle cycle and some slack per write
    localparam int cyclesPerWrite = 7;
    localparam int marginCycles   = 1384;
    localparam int timeoutCycles  = expectedWrites * cyclesPerWrite + marginCycles;

    logic                clk;
    logic                rstN;
    logic                flashInit;
    logic                wbAck;
    logic                wbCyc;
    logic                wbStb;
    logic                wbWe;
    logic [bootAdrW-1:0] wbAdr;
    logic [bootDatW-1:0] wbDatO;
    logic                systemEnable;

    integer seed;
    int     ackWait;
    int     cycleCount;
    int     writeCount;
    int     mismatchErrors;
    int     otherErrors;
    logic   started;
    logic   enableSeen;

    // Shadow of the system memories and per-index write counters
    logic [bootDatW-1:0] instShadow [instWordsTb];
    logic [bootDatW-1:0] dataShadow [dataWordsTb];
    int                  instWrites [instWordsTb];
    int                  dataWrites [dataWordsTb];

    bootLoaderTop #(
        .instWords(instWordsTb),
        .dataWords(dataWordsTb),
        .mmioStart(mmioStartTb),
        .mmioEnd  (mmioEndTb),
        .fifoDepth(fifoDepthTb)
    ) i_dut (
        .clk         (clk),
        .rstN        (rstN),
        .flashInit   (flashInit),
        .wbAck       (wbAck),
        .wbCyc       (wbCyc),
        .wbStb       (wbStb),
        .wbWe        (wbWe),
        .wbAdr       (wbAdr),
        .wbDatO      (wbDatO),
        .systemEnable(systemEnable)
    );

    // Boot image rules, 16-bit wrap
    function automatic logic [bootDatW-1:0] instRule(int idx);
        logic [bootDatW-1:0] idx16;
        idx16 = idx[bootDatW-1:0];
        return idx16 * 16'h1F3D + 16'h0101;
    endfunction

    function automatic logic [bootDatW-1:0] dataRule(int idx);
        logic [bootDatW-1:0] idx16;
        idx16 = idx[bootDatW-1:0];
        return (idx16 * 16'h2B47) ^ 16'hC35A;
    endfunction

    function automatic bit inWindow(int idx);
        return (idx >= mmioStartTb) && (idx <= mmioEndTb);
    endfunction

    task automatic recordWrite(input logic [bootAdrW-1:0] adr, input logic [bootDatW-1:0] dat);
        int                  idx;
        logic [bootDatW-1:0] expected;
        idx = int'(adr[bootIdxW-1:0]);
        writeCount++;
        if (bootTarget_t'(adr[bootAdrW-1]) == targetInst) begin
            assert (idx < instWordsTb) else begin
                otherErrors++;
                $display("Instruction write at %0t to index %0d past the end", $time, idx);
            end
            if (idx < instWordsTb) begin
                expected = instRule(idx);
                assert (dat == expected) else begin
                    mismatchErrors++;
                    $display("Mismatch at %0t: instruction %0d written %h, expected %h",
                             $time, idx, dat, expected);
                end
                assert (instWrites[idx] == 0) else begin
                    otherErrors++;
                    $display("Instruction index %0d written again at %0t", idx, $time);
                end
                instShadow[idx] = dat;
                instWrites[idx]++;
            end
        end else begin
            assert (idx < dataWordsTb) else begin
                otherErrors++;
                $display("Data write at %0t to index %0d past the end", $time, idx);
            end
            assert (!inWindow(idx)) else begin
                otherErrors++;
                $display("Data write at %0t into reserved index %0d", $time, idx);
            end
            if (idx < dataWordsTb) begin
                if (!inWindow(idx)) begin
                    expected = dataRule(idx);
                    assert (dat == expected) else begin
                        mismatchErrors++;
                        $display("Mismatch at %0t: data %0d written %h, expected %h",
                                 $time, idx, dat, expected);
                    end
                    assert (dataWrites[idx] == 0) else begin
                        otherErrors++;
                        $display("Data index %0d written again at %0t", idx, $time);
                    end
                    dataShadow[idx] = dat;
                end
                dataWrites[idx]++;
            end
        end
    endtask

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Slave model, ack after 0 to 4 extra cycles of strobe
    always @(negedge clk) begin
        if (!rstN || wbAck) begin
            wbAck   = 1'b0;
            ackWait = -1;
        end else if (wbCyc && wbStb) begin
            if (ackWait < 0) begin
                ackWait = $unsigned($random(seed)) % 5;
            end
            if (ackWait == 0) begin
                wbAck = 1'b1;
            end else begin
                ackWait--;
            end
        end
    end

    // Bus protocol
    assert property (@(posedge clk) disable iff (!rstN) wbStb |-> (wbCyc && wbWe))
        else begin
            otherErrors++;
            $display("Strobe at %0t without cycle or write enable", $time);
        end

    assert property (@(posedge clk) disable iff (!rstN)
        (wbStb && !wbAck) |=> ($stable(wbAdr) && $stable(wbDatO)))
        else begin
            mismatchErrors++;
            $display("Mismatch at %0t: address or data moved before the acknowledge", $time);
        end

    // Monitor, enable checks come before the write of the same edge is counted
    always @(posedge clk) begin
        if (rstN) begin
            if (!started) begin
                assert (!wbCyc && !wbStb && !systemEnable) else begin
                    otherErrors++;
                    $display("Bus or systemEnable active at %0t before flashInit", $time);
                end
            end
            if (systemEnable) begin
                assert (writeCount == expectedWrites) else begin
                    otherErrors++;
                    $display("systemEnable high at %0t after only %0d of %0d writes",
                             $time, writeCount, expectedWrites);
                end
                enableSeen = 1'b1;
            end else begin
                assert (!enableSeen) else begin
                    otherErrors++;
                    $display("systemEnable dropped at %0t", $time);
                end
            end
            if (enableSeen) begin
                assert (!wbCyc) else begin
                    otherErrors++;
                    $display("Bus cycle at %0t after systemEnable rose", $time);
                end
            end
            if (wbCyc && wbStb && wbAck) begin
                recordWrite(wbAdr, wbDatO);
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout after %0d cycles, load did not finish", cycleCount);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        seed           = 32'hed20_4bdd;
        rstN           = 1'b0;
        flashInit      = 1'b0;
        wbAck          = 1'b0;
        ackWait        = -1;
        cycleCount     = 0;
        writeCount     = 0;
        mismatchErrors = 0;
        otherErrors    = 0;
        started        = 1'b0;
        enableSeen     = 1'b0;
        for (int i = 0; i < instWordsTb; i++) begin
            instWrites[i] = 0;
        end
        for (int i = 0; i < dataWordsTb; i++) begin
            dataWrites[i] = 0;
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        // Quiet period before the start pulse
        repeat (5) @(negedge clk);
        flashInit = 1'b1;
        started   = 1'b1;
        @(negedge clk);
        flashInit = 1'b0;

        while (!systemEnable) begin
            @(negedge clk);
        end

        // Second start is ignored
        flashInit = 1'b1;
        @(negedge clk);
        flashInit = 1'b0;
        repeat (20) @(negedge clk);

        for (int i = 0; i < instWordsTb; i++) begin
            assert (instWrites[i] == 1) else begin
                otherErrors++;
                $display("Instruction index %0d written %0d times", i, instWrites[i]);
            end
            if (instWrites[i] == 1) begin
                assert (instShadow[i] == instRule(i)) else begin
                    mismatchErrors++;
                    $display("Mismatch at %0t: instruction memory %0d holds %h",
                             $time, i, instShadow[i]);
                end
            end
        end
        for (int i = 0; i < dataWordsTb; i++) begin
            assert (dataWrites[i] == (inWindow(i) ? 0 : 1)) else begin
                otherErrors++;
                $display("Data index %0d written %0d times", i, dataWrites[i]);
            end
            if (!inWindow(i) && dataWrites[i] == 1) begin
                assert (dataShadow[i] == dataRule(i)) else begin
                    mismatchErrors++;
                    $display("Mismatch at %0t: data memory %0d holds %h", $time, i, dataShadow[i]);
                end
            end
        end
        assert (writeCount == expectedWrites) else begin
            mismatchErrors++;
            $display("Mismatch at %0t: %0d writes seen, expected %0d",
                     $time, writeCount, expectedWrites);
        end
        assert (systemEnable) else begin
            otherErrors++;
            $display("systemEnable is low at the end of the run");
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatchErrors, otherErrors);
        if (mismatchErrors + otherErrors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: src.f
bootPkg.sv
bootImageRom.sv
flashSequencer.sv
bootFifo.sv
wbBootMaster.sv
bootLoaderTop.sv
tbBootLoader.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f src.f \
		--top-module tbBootLoader -Mdir obj_dir -o simBootLoader
	./obj_dir/simBootLoader > sim.log 2>&1
	cat sim.log
	@if grep -q "FAIL: see errors above" sim.log; then \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
